//--- design/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// reorder buffer sizing, tag 0 is reserved for "in register file"
`define ROB_TAG_LEN 4
`define ROB_DEPTH   8

// architectural registers
`define NUM_REGS    32

// major opcodes
`define OP_ALU      7'b0110011
`define OP_ALU_IMM  7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011

`endif

//--- design/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // immediate layout, imm overlays funct7 and rs2
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_t;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       rs2_used;
    logic       writes_rd;
  } decoded_regs_t;

  typedef struct packed {
    logic [`ROB_TAG_LEN-1:0] tag;
    logic                    ready;
    logic                    used;
  } map_packet_t;

  typedef struct packed {
    logic                    valid;
    logic [4:0]              rd;
    logic [`ROB_TAG_LEN-1:0] tag;
  } commit_t;

endpackage

//--- design/inst_decode.sv
`include "rename_defines.svh"

module inst_decode (
  input  rename_pkg::inst_t         inst,
  output rename_pkg::decoded_regs_t regs
);

  logic [6:0] opcode;
  logic       writes_rd;
  logic       rs2_used;

  assign opcode = inst.r.opcode;

  always_comb begin
    writes_rd = 1'b0;
    rs2_used  = 1'b0;
    case (opcode)
      `OP_ALU: begin
        writes_rd = 1'b1;
        rs2_used  = 1'b1;
      end
      `OP_ALU_IMM, `OP_LOAD: begin
        writes_rd = 1'b1; // rs2 slot holds imm bits
      end
      `OP_STORE, `OP_BRANCH: begin
        rs2_used = 1'b1; // rd slot holds imm bits
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    regs.writes_rd = writes_rd;
    regs.rs2_used  = rs2_used;
    regs.rs1       = inst.r.rs1;
    regs.rd        = writes_rd ? inst.r.rd : 5'd0;
    // unused rs2 reads as x0 so imm bits never hit the map
    regs.rs2       = rs2_used ? inst.r.rs2 : 5'd0;
  end

endmodule

//--- design/map_table.sv
`include "rename_defines.svh"

module map_table (
  input  logic                      clock,
  input  logic                      reset,
  input  rename_pkg::decoded_regs_t regs,
  input  logic                      dispatch,
  input  logic [`ROB_TAG_LEN-1:0]   alloc_tag,
  input  logic                      wb_valid,
  input  logic [`ROB_TAG_LEN-1:0]   wb_tag,
  input  rename_pkg::commit_t       commit,
  input  logic                      branch_speculating,
  input  logic                      branch_determined,
  input  logic                      branch_misprediction,
  output rename_pkg::map_packet_t   rs1_packet,
  output rename_pkg::map_packet_t   rs2_packet
);
  import rename_pkg::*;

  localparam int TAG_LEN = `ROB_TAG_LEN;

  logic [TAG_LEN-1:0]   tag_q [`NUM_REGS];
  logic [TAG_LEN-1:0]   tag_d [`NUM_REGS];
  logic [`NUM_REGS-1:0] ready_q;
  logic [`NUM_REGS-1:0] ready_d;

  // checkpoint taken at branch dispatch
  logic [TAG_LEN-1:0]   ckpt_tag_q [`NUM_REGS];
  logic [TAG_LEN-1:0]   ckpt_tag_d [`NUM_REGS];
  logic [`NUM_REGS-1:0] ckpt_ready_q;
  logic [`NUM_REGS-1:0] ckpt_ready_d;

  logic wb_live;
  logic squash;
  logic install;

  assign wb_live = wb_valid && wb_tag != '0;
  assign squash  = branch_determined && branch_misprediction;
  assign install = dispatch && regs.writes_rd && regs.rd != '0 && !squash; // wrong path dropped

  function automatic map_packet_t lookup(input logic [4:0] src, input logic used);
    map_packet_t p;
    p.used = used;
    if (src == '0) begin
      p.tag   = '0;
      p.ready = 1'b1;
    end else begin
      p.tag   = tag_q[src];
      p.ready = ready_q[src] || (wb_live && wb_tag == tag_q[src]); // forward
    end
    return p;
  endfunction

  always_comb begin
    rs1_packet = lookup(regs.rs1, 1'b1);
    rs2_packet = lookup(regs.rs2, regs.rs2_used);
  end

  always_comb begin
    tag_d        = tag_q;
    ready_d      = ready_q;
    ckpt_tag_d   = ckpt_tag_q;
    ckpt_ready_d = ckpt_ready_q;

    // writeback wakes every register still pointing at the tag
    for (int r = 1; r < `NUM_REGS; r++) begin
      if (wb_live && tag_q[r] == wb_tag) begin
        ready_d[r] = 1'b1;
      end
      if (wb_live && ckpt_tag_q[r] == wb_tag) begin
        ckpt_ready_d[r] = 1'b1;
      end
    end

    // retire clears only a mapping that is still current
    if (commit.valid && commit.rd != '0) begin
      if (tag_q[commit.rd] == commit.tag) begin
        tag_d[commit.rd]   = '0;
        ready_d[commit.rd] = 1'b0;
      end
      if (ckpt_tag_q[commit.rd] == commit.tag) begin
        ckpt_tag_d[commit.rd]   = '0;
        ckpt_ready_d[commit.rd] = 1'b0;
      end
    end

    if (install) begin
      tag_d[regs.rd]   = alloc_tag;
      ready_d[regs.rd] = 1'b0;
      if (!branch_speculating) begin
        ckpt_tag_d[regs.rd]   = alloc_tag;
        ckpt_ready_d[regs.rd] = 1'b0;
      end
    end

    if (squash) begin
      tag_d   = ckpt_tag_d;
      ready_d = ckpt_ready_d;
    end else if (branch_determined) begin
      ckpt_tag_d   = tag_d; // branch was right, speculative state is now real
      ckpt_ready_d = ready_d;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_q        <= '{default: '0};
      ready_q      <= '0;
      ckpt_tag_q   <= '{default: '0};
      ckpt_ready_q <= '0;
    end else begin
      tag_q        <= tag_d;
      ready_q      <= ready_d;
      ckpt_tag_q   <= ckpt_tag_d;
      ckpt_ready_q <= ckpt_ready_d;
    end
  end

endmodule

//--- design/reorder_buffer.sv
`include "rename_defines.svh"

module reorder_buffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch,
  input  logic [4:0]              rd,
  input  logic                    wb_valid,
  input  logic [`ROB_TAG_LEN-1:0] wb_tag,
  input  logic                    branch_speculating,
  input  logic                    branch_determined,
  input  logic                    branch_misprediction,
  output logic [`ROB_TAG_LEN-1:0] alloc_tag,
  output logic                    full,
  output rename_pkg::commit_t     commit
);

  localparam int TAG_LEN = `ROB_TAG_LEN;
  localparam int IDX_LEN = $clog2(`ROB_DEPTH);
  localparam int CNT_LEN = $clog2(`ROB_DEPTH + 1);

  logic [IDX_LEN-1:0]    head;
  logic [IDX_LEN-1:0]    tail;
  logic [CNT_LEN-1:0]    count;
  logic [CNT_LEN-1:0]    spec_cnt;
  logic [4:0]            rd_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] done_q;
  logic [`ROB_DEPTH-1:0] spec_q;

  logic               squash;
  logic               alloc;
  logic               alloc_spec;
  logic               retire;
  logic [IDX_LEN-1:0] wb_idx;

  assign squash     = branch_determined && branch_misprediction;
  assign alloc      = dispatch && !squash;
  assign alloc_spec = branch_speculating && !branch_determined;
  assign retire     = commit.valid;
  assign wb_idx     = IDX_LEN'(wb_tag - 1'b1); // tags are index + 1

  assign alloc_tag = TAG_LEN'(tail) + 1'b1;
  assign full      = count == CNT_LEN'(`ROB_DEPTH);

  always_comb begin
    commit.valid = count != '0 && done_q[head] && !spec_q[head];
    commit.rd    = rd_q[head];
    commit.tag   = TAG_LEN'(head) + 1'b1;
  end

  // marked entries sit together at the young end, so their number is how
  // far the tail moves back on a squash
  always_comb begin
    spec_cnt = '0;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      spec_cnt = spec_cnt + CNT_LEN'(spec_q[i]);
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      rd_q[tail] <= rd;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head   <= '0;
      tail   <= '0;
      count  <= '0;
      done_q <= '0;
      spec_q <= '0;
    end else begin
      if (alloc) begin
        done_q[tail] <= 1'b0;
        spec_q[tail] <= alloc_spec;
        tail         <= tail + 1'b1;
      end

      if (wb_valid && wb_tag != '0) begin
        done_q[wb_idx] <= 1'b1;
      end

      if (retire) begin
        head <= head + 1'b1;
      end

      if (squash) begin
        spec_q <= '0;
        tail   <= tail - IDX_LEN'(spec_cnt);
      end else if (branch_determined) begin
        spec_q <= '0; // correct prediction
      end

      count <= count + CNT_LEN'(alloc) - CNT_LEN'(retire)
               - (squash ? spec_cnt : CNT_LEN'(0));
    end
  end

endmodule

//--- design/rename_unit.sv
`include "rename_defines.svh"

module rename_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch,
  input  rename_pkg::inst_t       inst,
  input  logic                    wb_valid,
  input  logic [`ROB_TAG_LEN-1:0] wb_tag,
  input  logic                    branch_speculating,
  input  logic                    branch_determined,
  input  logic                    branch_misprediction,
  output rename_pkg::map_packet_t rs1_packet,
  output rename_pkg::map_packet_t rs2_packet,
  output logic [`ROB_TAG_LEN-1:0] alloc_tag,
  output logic                    full,
  output rename_pkg::commit_t     commit
);
  import rename_pkg::*;

  decoded_regs_t regs;

  inst_decode u_decode (
    .inst (inst),
    .regs (regs)
  );

  map_table u_map (
    .clock                (clock),
    .reset                (reset),
    .regs                 (regs),
    .dispatch             (dispatch),
    .alloc_tag            (alloc_tag),
    .wb_valid             (wb_valid),
    .wb_tag               (wb_tag),
    .commit               (commit),
    .branch_speculating   (branch_speculating),
    .branch_determined    (branch_determined),
    .branch_misprediction (branch_misprediction),
    .rs1_packet           (rs1_packet),
    .rs2_packet           (rs2_packet)
  );

  // rd is already zero when the instruction has no destination
  reorder_buffer u_rob (
    .clock                (clock),
    .reset                (reset),
    .dispatch             (dispatch),
    .rd                   (regs.rd),
    .wb_valid             (wb_valid),
    .wb_tag               (wb_tag),
    .branch_speculating   (branch_speculating),
    .branch_determined    (branch_determined),
    .branch_misprediction (branch_misprediction),
    .alloc_tag            (alloc_tag),
    .full                 (full),
    .commit               (commit)
  );

endmodule

//--- tests/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef struct packed {
  logic [`ROB_TAG_LEN-1:0] tag;
  logic [4:0]              rd;
  logic                    done;
  logic                    spec;
} rob_entry_t;

logic [`ROB_TAG_LEN-1:0] live_tag   [`NUM_REGS];
logic                    live_ready [`NUM_REGS];
logic [`ROB_TAG_LEN-1:0] ckpt_tag   [`NUM_REGS];
logic                    ckpt_ready [`NUM_REGS];
rob_entry_t              pending [$]; // oldest first
logic [`ROB_TAG_LEN-1:0] next_tag;

task automatic clear_state();
  for (int r = 0; r < `NUM_REGS; r++) begin
    live_tag[r]   = '0;
    live_ready[r] = 1'b0;
    ckpt_tag[r]   = '0;
    ckpt_ready[r] = 1'b0;
  end
  pending.delete();
  next_tag = 1;
endtask

function automatic logic writes_dest(input logic [6:0] op);
  return op == `OP_ALU || op == `OP_ALU_IMM || op == `OP_LOAD;
endfunction

function automatic logic reads_rs2(input logic [6:0] op);
  return op == `OP_ALU || op == `OP_STORE || op == `OP_BRANCH;
endfunction

function automatic map_packet_t predict_packet(input logic [4:0] src, input logic used,
                                               input logic wb_on,
                                               input logic [`ROB_TAG_LEN-1:0] wtag);
  map_packet_t p;
  p.used  = used;
  p.tag   = (src == 0) ? '0 : live_tag[src];
  p.ready = (src == 0) || live_ready[src] || (wb_on && wtag != 0 && wtag == live_tag[src]);
  return p;
endfunction

function automatic commit_t predict_commit();
  commit_t c;
  c = '0;
  if (pending.size() > 0 && pending[0].done && !pending[0].spec) begin
    c.valid = 1'b1;
    c.rd    = pending[0].rd;
    c.tag   = pending[0].tag;
  end
  return c;
endfunction

task automatic update_on_edge(input logic [31:0] word, input logic disp, input logic wb_on,
                              input logic [`ROB_TAG_LEN-1:0] wtag, input logic spec,
                              input logic resolved, input logic wrong);
  commit_t    c;
  rob_entry_t e;
  logic       squash;
  logic [4:0] rd;
  c      = predict_commit();
  squash = resolved && wrong;
  rd     = writes_dest(word[6:0]) ? word[11:7] : 5'd0;
  for (int r = 1; r < `NUM_REGS; r++) begin
    if (wb_on && wtag != 0 && live_tag[r] == wtag) live_ready[r] = 1'b1;
    if (wb_on && wtag != 0 && ckpt_tag[r] == wtag) ckpt_ready[r] = 1'b1;
  end
  if (c.valid && c.rd != 0 && live_tag[c.rd] == c.tag) begin
    live_tag[c.rd]   = '0;
    live_ready[c.rd] = 1'b0;
  end
  if (c.valid && c.rd != 0 && ckpt_tag[c.rd] == c.tag) begin
    ckpt_tag[c.rd]   = '0;
    ckpt_ready[c.rd] = 1'b0;
  end
  if (disp && rd != 0 && !squash) begin
    live_tag[rd]   = next_tag;
    live_ready[rd] = 1'b0;
    if (!spec) begin
      ckpt_tag[rd]   = next_tag;
      ckpt_ready[rd] = 1'b0;
    end
  end
  if (squash) begin
    live_tag   = ckpt_tag;
    live_ready = ckpt_ready;
  end else if (resolved) begin
    ckpt_tag   = live_tag;
    ckpt_ready = live_ready;
  end
  // buffer side
  foreach (pending[i]) begin
    e = pending[i];
    if (wb_on && e.tag == wtag) e.done = 1'b1;
    pending[i] = e;
  end
  if (c.valid) void'(pending.pop_front());
  if (disp && !squash) begin
    e.tag  = next_tag;
    e.rd   = rd;
    e.done = 1'b0;
    e.spec = spec && !resolved;
    pending.push_back(e);
    next_tag = (next_tag == `ROB_DEPTH) ? 1 : next_tag + 1;
  end
  while (squash && pending.size() > 0 && pending[$].spec) begin
    next_tag = pending[$].tag; // tail rewinds to oldest wrong-path tag
    void'(pending.pop_back());
  end
  foreach (pending[i]) begin
    e = pending[i];
    if (resolved) e.spec = 1'b0;
    pending[i] = e;
  end
endtask

`endif

//--- tests/tb_rename_unit.sv
`include "rename_defines.svh"

module tb_rename_unit;
  import rename_pkg::*;

  localparam int NUM_CYCLES  = 2000;
  localparam int CYCLE_LIMIT = 4 * NUM_CYCLES;

  logic                    clock;
  logic                    reset;
  logic                    dispatch;
  logic [31:0]             word;
  inst_t                   inst;
  logic                    wb_valid;
  logic [`ROB_TAG_LEN-1:0] wb_tag;
  logic                    branch_speculating;
  logic                    branch_determined;
  logic                    branch_misprediction;
  map_packet_t             rs1_packet;
  map_packet_t             rs2_packet;
  logic [`ROB_TAG_LEN-1:0] alloc_tag;
  logic                    full;
  commit_t                 commit;

  integer seed = 86061;
  int     cycle_count = 0;
  int     gap;
  int     window_left;
  int     commits_seen = 0;
  int     squashes_seen = 0;

  `include "rename_model.svh"

  assign inst = word;

  rename_unit uut (.*);

  initial clock = 1'b0;
  always #10 clock = ~clock;

  task automatic stop_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_with_failure();
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("Error: %s at cycle %0d expected %0h actual %0h", name, cycle_count,
               expected, actual);
      stop_with_failure();
    end
  endtask

  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = $random(seed);
    return (r[4:3] == 2'b00) ? r[9:5] : {2'b00, r[2:0]}; // mostly low regs
  endfunction

  function automatic logic [6:0] pick_opcode();
    case ($unsigned($random(seed)) % 5)
      0: return `OP_ALU;
      1: return `OP_ALU_IMM;
      2: return `OP_LOAD;
      3: return `OP_STORE;
      default: return `OP_BRANCH;
    endcase
  endfunction

  task automatic drive_stimulus();
    logic [31:0] r;
    int          open_idx [$];
    r        = $random(seed);
    word     = {r[31:25], pick_reg(), pick_reg(), r[14:12], pick_reg(), pick_opcode()};
    dispatch = r[0] && pending.size() < `ROB_DEPTH;
    foreach (pending[i]) if (!pending[i].done) open_idx.push_back(i);
    wb_valid = r[3:2] != 2'b00 && open_idx.size() > 0;
    wb_tag   = r[7:4];
    if (wb_valid) wb_tag = pending[open_idx[$unsigned($random(seed)) % open_idx.size()]].tag;
    branch_determined    = 1'b0;
    branch_misprediction = r[8]; // only meaningful with determined
    if (window_left > 0) begin
      window_left--;
      if (window_left == 0) begin
        branch_determined = 1'b1;
        if (branch_misprediction) squashes_seen++;
      end
    end else if (branch_speculating) begin
      branch_speculating = 1'b0;
      gap = 20 + $unsigned($random(seed)) % 30;
    end else if (gap > 0) begin
      gap--;
    end else begin
      branch_speculating = 1'b1;
      window_left = 2 + $unsigned($random(seed)) % 12;
    end
  endtask

  task automatic check_outputs();
    map_packet_t exp_rs1;
    map_packet_t exp_rs2;
    commit_t     exp_commit;
    logic        used2;
    used2      = reads_rs2(word[6:0]);
    exp_rs1    = predict_packet(word[19:15], 1'b1, wb_valid, wb_tag);
    exp_rs2    = predict_packet(used2 ? word[24:20] : 5'd0, used2, wb_valid, wb_tag);
    exp_commit = predict_commit();
    check_value("rename rs1_packet", exp_rs1, rs1_packet);
    check_value("rename rs2_packet", exp_rs2, rs2_packet);
    check_value("alloc_tag", next_tag, alloc_tag);
    check_value("full", pending.size() == `ROB_DEPTH, full);
    check_value("commit valid", exp_commit.valid, commit.valid);
    if (exp_commit.valid) begin
      check_value("commit rd", exp_commit.rd, commit.rd);
      check_value("commit tag", exp_commit.tag, commit.tag);
      commits_seen++;
    end
  endtask

  initial begin
    reset                = 1'b1;
    dispatch             = 1'b0;
    word                 = '0;
    wb_valid             = 1'b0;
    wb_tag               = '0;
    branch_speculating   = 1'b0;
    branch_determined    = 1'b0;
    branch_misprediction = 1'b0;
    gap                  = 10;
    window_left          = 0;
    clear_state();
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < NUM_CYCLES; i++) begin
      drive_stimulus();
      #5;
      check_outputs();
      @(posedge clock);
      update_on_edge(word, dispatch, wb_valid, wb_tag, branch_speculating,
                     branch_determined, branch_misprediction);
      @(negedge clock);
    end
    $display("%0d commits checked, %0d mispredictions", commits_seen, squashes_seen);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- tb.f
+incdir+design
+incdir+tests
design/rename_pkg.sv
design/inst_decode.sv
design/map_table.sv
design/reorder_buffer.sv
design/rename_unit.sv
tests/tb_rename_unit.sv

//--- Bender.yml
package:
  name: rename_unit

sources:
  - include_dirs:
      - design
    files:
      - design/rename_pkg.sv
      - design/inst_decode.sv
      - design/map_table.sv
      - design/reorder_buffer.sv
      - design/rename_unit.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/tb_rename_unit.sv
